/* logic/netpkt_pkg.sv */
// Packet stream beat, DMA write request and fixed datapath widths for the receive path
package netpkt_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Fixed widths
	//////////////////////////////////////////////////////////////////////////////

	// One packet beat equals one bus word
	localparam int PKT_DW = 64;
	// Byte count in a beat, zero means all 8 bytes
	localparam int PKT_BW = 3;
	// DMA word address
	localparam int MEM_AW = 24;

	//////////////////////////////////////////////////////////////////////////////
	// Stream and bus bundles
	//////////////////////////////////////////////////////////////////////////////

	// Stream beat, first byte on the wire in data[63:56]
	typedef struct packed {
		logic [PKT_DW-1:0] data;
		logic [PKT_BW-1:0] bytes;
		logic              last;
		logic              abort;
	} pkt_beat_t;

	// Single outstanding write, address in bus words
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic [MEM_AW-1:0] addr;
		logic [PKT_DW-1:0] data;
	} dma_req_t;

endpackage

/* logic/cpunet_pkg.sv */
// Register map, CONTROL bit positions and buffer configuration for the CPU network receive port
package cpunet_pkg;

	//////////////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////////////

	// Registers are whole 32-bit words
	localparam int REG_DW = 32;

	// Word addresses on the CPU bus
	typedef enum logic [4:0] {
		CONTROL  = 5'h00,
		MAC_HI   = 5'h01,
		MAC_LO   = 5'h02,
		// Statistics, any write clears
		RX_DROPS = 5'h08,
		RX_PKTS  = 5'h09,
		// Circular buffer
		BUF_BASE = 5'h10,
		BUF_SIZE = 5'h11,
		// Read only, committed write pointer
		WR_PTR   = 5'h12,
		RD_PTR   = 5'h13
	} reg_addr_e;

	// CONTROL bits
	localparam int CTRL_PROMISC = 0;
	localparam int CTRL_ENABLE  = 1;
	// Reads as the error flag, writing a one clears it
	localparam int CTRL_MEMERR  = 2;

	//////////////////////////////////////////////////////////////////////////////
	// Writer configuration
	//////////////////////////////////////////////////////////////////////////////

	// Base and size in bus words, rd_ptr relative to base
	typedef struct packed {
		logic                          fifo_reset;
		logic [netpkt_pkg::MEM_AW-1:0] base;
		logic [netpkt_pkg::MEM_AW-1:0] size;
		logic [netpkt_pkg::MEM_AW-1:0] rd_ptr;
	} rx_cfg_t;

endpackage

/* logic/mac_filter.sv */
// Destination MAC filter that forwards whole packets addressed to the CPU and swallows the rest
module mac_filter #(
	parameter logic [47:0] CPU_MAC = 48'h0
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_promisc,
	// Incoming stream
	input  logic                  i_valid,
	input  netpkt_pkg::pkt_beat_t i_beat,
	output logic                  o_ready,
	// Filtered stream
	output logic                  o_valid,
	output netpkt_pkg::pkt_beat_t o_beat,
	input  logic                  i_ready,
	// One pulse per rejected packet
	output logic                  o_drop
);

	typedef enum logic [1:0] {IDLE, PASS, DISCARD} flt_state_e;

	flt_state_e state;
	logic       mac_hit;
	logic       xfer;
	logic       pkt_end;

	// Bytes 0 to 5 of the first beat
	assign mac_hit = i_promisc
		|| (i_beat.data[netpkt_pkg::PKT_DW-1 -: 48] == CPU_MAC);
	assign xfer    = i_valid && o_ready;
	assign pkt_end = i_beat.last || i_beat.abort;

	// Beats go straight through, payload untouched
	assign o_beat = i_beat;

	//////////////////////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
		// Writer back-pressure holds even a beat about to be rejected
		IDLE: begin
			o_ready = i_ready;
			o_valid = i_valid && mac_hit;
		end
		PASS: begin
			o_ready = i_ready;
			o_valid = i_valid;
		end
		// Swallow until the end of the packet
		default: begin
			o_ready = 1'b1;
			o_valid = 1'b0;
		end
		endcase
	end

	//////////////////////////////////////////////////////////////////////////////
	// Packet state
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state  <= IDLE;
			o_drop <= 1'b0;
		end else begin
			o_drop <= (state == IDLE) && xfer && !mac_hit;
			if (xfer) begin
				if (pkt_end)
					state <= IDLE;
				else if (state == IDLE)
					state <= mac_hit ? PASS : DISCARD;
			end
		end
	end

endmodule

/* logic/rx_vfifo_writer.sv */
// Virtual packet FIFO writer placing accepted packets in a circular memory buffer over DMA
module rx_vfifo_writer (
	input  logic                          i_clk,
	input  logic                          i_reset,
	input  cpunet_pkg::rx_cfg_t           i_cfg,
	// Accepted packet beats
	input  logic                          i_valid,
	input  netpkt_pkg::pkt_beat_t         i_beat,
	output logic                          o_ready,
	// DMA write bus
	output netpkt_pkg::dma_req_t          o_dma,
	input  logic                          i_dma_stall,
	input  logic                          i_dma_ack,
	input  logic                          i_dma_err,
	// Status to the register block
	output logic [netpkt_pkg::MEM_AW-1:0] o_wr_ptr,
	output logic                          o_pkt_done,
	output logic                          o_pkt_drop,
	output logic                          o_bus_err
);

	typedef enum logic [1:0] {IDLE, DATA, WAIT_ACK, LENGTH} wr_state_e;

	wr_state_e                     state;
	logic [netpkt_pkg::MEM_AW-1:0] wk_ptr;
	logic [netpkt_pkg::MEM_AW-1:0] next_slot;
	logic [31:0]                   byte_cnt;
	logic [3:0]                    beat_bytes;
	logic                          r_last;
	logic                          r_skip;
	logic                          in_pkt;
	logic                          full;
	logic                          take;
	logic                          start_data;
	logic                          start_len;
	logic                          err_hit;
	logic                          dma_cyc;
	logic                          dma_stb;
	logic [netpkt_pkg::MEM_AW-1:0] dma_addr;
	logic [netpkt_pkg::PKT_DW-1:0] dma_data;

	// Step a buffer offset, wrapping at size
	function automatic logic [netpkt_pkg::MEM_AW-1:0] ptr_inc(
		input logic [netpkt_pkg::MEM_AW-1:0] ptr,
		input logic [netpkt_pkg::MEM_AW-1:0] size
	);
		logic [netpkt_pkg::MEM_AW-1:0] nxt;
		nxt = ptr + 1'b1;
		return (nxt >= size) ? '0 : nxt;
	endfunction

	assign next_slot  = ptr_inc(wk_ptr, i_cfg.size);
	assign beat_bytes = (i_beat.bytes == '0) ? 4'd8 : {1'b0, i_beat.bytes};
	// Keep the unread slot and the new commit point off rd_ptr
	assign full    = (wk_ptr == i_cfg.rd_ptr) || (next_slot == i_cfg.rd_ptr);
	// Packet has started but its last beat is not in yet
	assign in_pkt  = (state == DATA) || (state == WAIT_ACK && !r_last);
	assign err_hit = dma_cyc && i_dma_err && (state == WAIT_ACK || state == LENGTH);

	// Ready drops the cycle after an error, before the fifo reset arrives
	assign o_ready = !i_cfg.fifo_reset && !dma_cyc && !o_bus_err
		&& (r_skip || ((state == IDLE || state == DATA) && !full));
	assign take       = i_valid && o_ready;
	assign start_data = take && !r_skip && !i_beat.abort;
	assign start_len  = (state == WAIT_ACK) && i_dma_ack && r_last && !i_cfg.fifo_reset;

	//////////////////////////////////////////////////////////////////////////////
	// Packet FSM and pointers
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset || i_cfg.fifo_reset) begin
			state    <= IDLE;
			o_wr_ptr <= '0;
			wk_ptr   <= ptr_inc('0, i_cfg.size);
			byte_cnt <= '0;
			r_last   <= 1'b0;
		end else begin
			case (state)
			IDLE, DATA: begin
				if (take && !r_skip && i_beat.abort) begin
					// Rewind to just past the committed pointer
					wk_ptr   <= ptr_inc(o_wr_ptr, i_cfg.size);
					byte_cnt <= '0;
					state    <= IDLE;
				end else if (start_data) begin
					wk_ptr   <= next_slot;
					byte_cnt <= byte_cnt + 32'(beat_bytes);
					r_last   <= i_beat.last;
					state    <= WAIT_ACK;
				end
			end
			WAIT_ACK, LENGTH: begin
				if (err_hit) begin
					wk_ptr   <= ptr_inc(o_wr_ptr, i_cfg.size);
					byte_cnt <= '0;
					state    <= IDLE;
				end else if (i_dma_ack && state == LENGTH) begin
					// Commit, next length word sits at the old working slot
					o_wr_ptr <= wk_ptr;
					wk_ptr   <= next_slot;
					byte_cnt <= '0;
					state    <= IDLE;
				end else if (i_dma_ack) begin
					state <= r_last ? LENGTH : DATA;
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

	// Status pulses and tail skipping of a broken packet
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_skip     <= 1'b0;
			o_pkt_done <= 1'b0;
			o_pkt_drop <= 1'b0;
			o_bus_err  <= 1'b0;
		end else begin
			o_pkt_done <= (state == LENGTH) && i_dma_ack && !i_cfg.fifo_reset;
			o_pkt_drop <= (take && !r_skip && i_beat.abort)
				|| (err_hit && !i_cfg.fifo_reset);
			o_bus_err  <= dma_cyc && i_dma_err;
			if (take && r_skip && (i_beat.last || i_beat.abort))
				r_skip <= 1'b0;
			else if (in_pkt && (err_hit || i_cfg.fifo_reset))
				r_skip <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// DMA request
	//////////////////////////////////////////////////////////////////////////////

	// Cycle always runs to ack or err, even across a fifo reset
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			dma_cyc <= 1'b0;
			dma_stb <= 1'b0;
		end else if (start_data || start_len) begin
			dma_cyc <= 1'b1;
			dma_stb <= 1'b1;
		end else if (i_dma_ack || i_dma_err) begin
			dma_cyc <= 1'b0;
			dma_stb <= 1'b0;
		end else if (!i_dma_stall) begin
			dma_stb <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (start_data) begin
			dma_addr <= i_cfg.base + wk_ptr;
			dma_data <= i_beat.data;
		end else if (start_len) begin
			// Length word goes in front of the data
			dma_addr <= i_cfg.base + o_wr_ptr;
			dma_data <= netpkt_pkg::PKT_DW'(byte_cnt);
		end
	end

	assign o_dma = '{cyc: dma_cyc, stb: dma_stb, addr: dma_addr, data: dma_data};

endmodule

/* logic/cpunet_regs.sv */
// CPU register block holding buffer configuration, error flag, packet counters and the rx interrupt
module cpunet_regs #(
	parameter logic [47:0] CPU_MAC = 48'h0
) (
	input  logic                              i_clk,
	input  logic                              i_reset,
	// CPU bus
	input  logic                              i_wb_stb,
	input  logic                              i_wb_we,
	input  cpunet_pkg::reg_addr_e             i_wb_addr,
	input  logic [cpunet_pkg::REG_DW-1:0]     i_wb_data,
	output logic                              o_wb_ack,
	output logic [cpunet_pkg::REG_DW-1:0]     o_wb_data,
	// Writer status
	input  logic [netpkt_pkg::MEM_AW-1:0]     i_wr_ptr,
	input  logic                              i_pkt_done,
	input  logic                              i_flt_drop,
	input  logic                              i_wr_drop,
	input  logic                              i_bus_err,
	// Configuration out
	output logic                              o_promisc,
	output cpunet_pkg::rx_cfg_t               o_cfg,
	output logic                              o_rx_int
);

	logic                          r_promisc;
	logic                          r_enable;
	logic                          mem_err;
	logic                          fifo_reset;
	logic [netpkt_pkg::MEM_AW-1:0] r_base;
	logic [netpkt_pkg::MEM_AW-1:0] r_size;
	logic [netpkt_pkg::MEM_AW-1:0] r_rd_ptr;
	logic [cpunet_pkg::REG_DW-1:0] rx_drops;
	logic [cpunet_pkg::REG_DW-1:0] rx_pkts;
	logic                          wr_stb;
	logic                          cfg_wr;

	assign wr_stb = i_wb_stb && i_wb_we;
	// New base or size restarts the buffer from zero
	assign cfg_wr = wr_stb
		&& (i_wb_addr == cpunet_pkg::BUF_BASE || i_wb_addr == cpunet_pkg::BUF_SIZE);

	//////////////////////////////////////////////////////////////////////////////
	// Control and configuration
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_promisc  <= 1'b0;
			r_enable   <= 1'b0;
			mem_err    <= 1'b0;
			fifo_reset <= 1'b1;
			r_base     <= '0;
			r_size     <= '0;
			r_rd_ptr   <= '0;
		end else begin
			// Buffer held in reset while disabled or after a bus error
			fifo_reset <= !r_enable || mem_err || cfg_wr || i_bus_err;
			if (wr_stb) begin
				case (i_wb_addr)
				cpunet_pkg::CONTROL: begin
					r_promisc <= i_wb_data[cpunet_pkg::CTRL_PROMISC];
					r_enable  <= i_wb_data[cpunet_pkg::CTRL_ENABLE];
					if (i_wb_data[cpunet_pkg::CTRL_MEMERR])
						mem_err <= 1'b0;
				end
				cpunet_pkg::BUF_BASE: r_base <= i_wb_data[netpkt_pkg::MEM_AW-1:0];
				cpunet_pkg::BUF_SIZE: r_size <= i_wb_data[netpkt_pkg::MEM_AW-1:0];
				cpunet_pkg::RD_PTR:   r_rd_ptr <= i_wb_data[netpkt_pkg::MEM_AW-1:0];
				default: begin
				end
				endcase
			end
			// Read pointer follows the writer back to zero
			if (fifo_reset)
				r_rd_ptr <= '0;
			// Error wins over a clear in the same cycle
			if (i_bus_err)
				mem_err <= 1'b1;
		end
	end

	assign o_promisc = r_promisc;
	assign o_cfg = '{fifo_reset: fifo_reset, base: r_base, size: r_size, rd_ptr: r_rd_ptr};

	//////////////////////////////////////////////////////////////////////////////
	// Counters and interrupt
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rx_drops <= '0;
			rx_pkts  <= '0;
			o_rx_int <= 1'b0;
		end else begin
			// Filter and writer drops may land in the same cycle
			if (wr_stb && i_wb_addr == cpunet_pkg::RX_DROPS)
				rx_drops <= '0;
			else
				rx_drops <= rx_drops + cpunet_pkg::REG_DW'(i_flt_drop)
					+ cpunet_pkg::REG_DW'(i_wr_drop);
			if (wr_stb && i_wb_addr == cpunet_pkg::RX_PKTS)
				rx_pkts <= '0;
			else if (i_pkt_done)
				rx_pkts <= rx_pkts + 1'b1;
			// Unread packets waiting
			o_rx_int <= (r_rd_ptr != i_wr_ptr);
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// Bus response
	//////////////////////////////////////////////////////////////////////////////

	// One cycle ack, no stall
	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= i_wb_stb;
	end

	always_ff @(posedge i_clk) begin
		o_wb_data <= '0;
		case (i_wb_addr)
		cpunet_pkg::CONTROL: begin
			o_wb_data[cpunet_pkg::CTRL_PROMISC] <= r_promisc;
			o_wb_data[cpunet_pkg::CTRL_ENABLE]  <= r_enable;
			o_wb_data[cpunet_pkg::CTRL_MEMERR]  <= mem_err;
		end
		cpunet_pkg::MAC_HI:   o_wb_data <= cpunet_pkg::REG_DW'(CPU_MAC[47:32]);
		cpunet_pkg::MAC_LO:   o_wb_data <= CPU_MAC[31:0];
		cpunet_pkg::RX_DROPS: o_wb_data <= rx_drops;
		cpunet_pkg::RX_PKTS:  o_wb_data <= rx_pkts;
		cpunet_pkg::BUF_BASE: o_wb_data <= cpunet_pkg::REG_DW'(r_base);
		cpunet_pkg::BUF_SIZE: o_wb_data <= cpunet_pkg::REG_DW'(r_size);
		cpunet_pkg::WR_PTR:   o_wb_data <= cpunet_pkg::REG_DW'(i_wr_ptr);
		cpunet_pkg::RD_PTR:   o_wb_data <= cpunet_pkg::REG_DW'(r_rd_ptr);
		default:              o_wb_data <= '0;
		endcase
	end

endmodule

/* logic/cpunet_rx.sv */
// Top level of the CPU network receive port joining MAC filter, packet writer and registers
module cpunet_rx #(
	parameter logic [47:0] CPU_MAC = 48'h1434_afa8_1234
) (
	input  logic                          i_clk,
	input  logic                          i_reset,
	// CPU register bus
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  cpunet_pkg::reg_addr_e         i_wb_addr,
	input  logic [cpunet_pkg::REG_DW-1:0] i_wb_data,
	output logic                          o_wb_ack,
	output logic [cpunet_pkg::REG_DW-1:0] o_wb_data,
	// Received packets
	input  logic                          i_rx_valid,
	input  netpkt_pkg::pkt_beat_t         i_rx,
	output logic                          o_rx_ready,
	// DMA write bus
	output netpkt_pkg::dma_req_t          o_dma,
	input  logic                          i_dma_stall,
	input  logic                          i_dma_ack,
	input  logic                          i_dma_err,
	output logic                          o_rx_int
);

	netpkt_pkg::pkt_beat_t         flt_beat;
	logic                          flt_valid;
	logic                          wr_ready;
	logic                          promisc;
	cpunet_pkg::rx_cfg_t           rx_cfg;
	logic [netpkt_pkg::MEM_AW-1:0] wr_ptr;
	logic                          pkt_done;
	logic                          flt_drop;
	logic                          wr_drop;
	logic                          bus_err;

	// Thin the stream down to our own MAC
	mac_filter #(.CPU_MAC(CPU_MAC)) u_filter (
		.i_clk(i_clk), .i_reset(i_reset), .i_promisc(promisc),
		.i_valid(i_rx_valid), .i_beat(i_rx), .o_ready(o_rx_ready),
		.o_valid(flt_valid), .o_beat(flt_beat), .i_ready(wr_ready),
		.o_drop(flt_drop)
	);

	// Everything accepted goes to memory for the CPU
	rx_vfifo_writer u_writer (
		.i_clk(i_clk), .i_reset(i_reset), .i_cfg(rx_cfg),
		.i_valid(flt_valid), .i_beat(flt_beat), .o_ready(wr_ready),
		.o_dma(o_dma), .i_dma_stall(i_dma_stall), .i_dma_ack(i_dma_ack),
		.i_dma_err(i_dma_err), .o_wr_ptr(wr_ptr), .o_pkt_done(pkt_done),
		.o_pkt_drop(wr_drop), .o_bus_err(bus_err)
	);

	cpunet_regs #(.CPU_MAC(CPU_MAC)) u_regs (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .o_wb_ack(o_wb_ack),
		.o_wb_data(o_wb_data), .i_wr_ptr(wr_ptr), .i_pkt_done(pkt_done),
		.i_flt_drop(flt_drop), .i_wr_drop(wr_drop), .i_bus_err(bus_err),
		.o_promisc(promisc), .o_cfg(rx_cfg), .o_rx_int(o_rx_int)
	);

endmodule

/* tb/cpunet_properties.sv */
// Protocol assertions for the receive port, attached to the top level with bind from the testbench
module cpunet_properties (
	input logic                 i_clk,
	input logic                 i_reset,
	input logic                 i_wb_stb,
	input logic                 i_wb_ack,
	input netpkt_pkg::dma_req_t i_dma,
	input logic                 i_dma_stall,
	input logic                 i_rx_ready,
	input logic                 i_flt_valid,
	input logic                 i_wr_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// Count of assertion failures
	int fails = 0;

	////////////////////////////////////////////////////////////////////////////
	// CPU bus
	////////////////////////////////////////////////////////////////////////////

	// Every strobe answered on the next cycle
	ack_after_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_stb |=> i_wb_ack)
	else begin
		$error("bus ack missing one cycle after strobe");
		fails++;
	end

	// No ack without a strobe before it
	ack_only_after_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_wb_stb |=> !i_wb_ack)
	else begin
		$error("bus ack without a strobe on the cycle before");
		fails++;
	end

	////////////////////////////////////////////////////////////////////////////
	// DMA bus and packet stream
	////////////////////////////////////////////////////////////////////////////

	// Request frozen while the memory stalls
	dma_hold_in_stall: assert property (@(posedge i_clk) disable iff (i_reset)
		i_dma.stb && i_dma_stall |=> i_dma.stb && $stable(i_dma.addr) && $stable(i_dma.data))
	else begin
		$error("DMA request changed under stall");
		fails++;
	end

	// Filter hands on only what the source gave up
	no_beat_without_ready: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_rx_ready |-> !(i_flt_valid && i_wr_ready))
	else begin
		$error("beat passed to the writer while o_rx_ready was low");
		fails++;
	end

endmodule

/* tb/cpunet_tb.sv */
// Testbench for the CPU network receive port with a stalling DMA memory model, run as top module
module cpunet_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [47:0] CPU_MAC = 48'h1434_afa8_1234;
	localparam logic [47:0] BAD_MAC = 48'h0200_5e00_0001;
	localparam int          TIMEOUT = 400;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_wb_stb;
	logic                  i_wb_we;
	cpunet_pkg::reg_addr_e i_wb_addr;
	logic [31:0]           i_wb_data;
	logic                  o_wb_ack;
	logic [31:0]           o_wb_data;
	logic                  i_rx_valid;
	netpkt_pkg::pkt_beat_t i_rx;
	logic                  o_rx_ready;
	netpkt_pkg::dma_req_t  o_dma;
	logic                  i_dma_stall;
	logic                  i_dma_ack;
	logic                  i_dma_err;
	logic                  o_rx_int;

	// Memory model state
	logic [63:0] mem [0:4095];
	logic [31:0] lfsr;
	logic        ack_due;
	logic        err_due;
	logic        err_arm;
	int          write_count;
	int          wc;

	cpunet_rx #(.CPU_MAC(CPU_MAC)) dut_i (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .o_wb_ack(o_wb_ack),
		.o_wb_data(o_wb_data), .i_rx_valid(i_rx_valid), .i_rx(i_rx),
		.o_rx_ready(o_rx_ready), .o_dma(o_dma), .i_dma_stall(i_dma_stall),
		.i_dma_ack(i_dma_ack), .i_dma_err(i_dma_err), .o_rx_int(o_rx_int)
	);

	bind cpunet_rx cpunet_properties u_props (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_stb(i_wb_stb), .i_wb_ack(o_wb_ack),
		.i_dma(o_dma), .i_dma_stall(i_dma_stall), .i_rx_ready(o_rx_ready),
		.i_flt_valid(flt_valid), .i_wr_ready(wr_ready)
	);

	always #5 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR with taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Destination MAC leads the first beat
	function automatic logic [63:0] beat_word(input int id, input int idx,
		input logic [47:0] mac);
		if (idx == 0)
			return {mac, 8'ha5, 8'(id)};
		return {8'(id), 8'(idx), 16'hc0de, 32'(id * 1000 + idx)};
	endfunction

	function automatic netpkt_pkg::pkt_beat_t make_beat(input int id, input int idx,
		input logic [47:0] mac, input logic last, input logic [2:0] bytes, input logic abort);
		netpkt_pkg::pkt_beat_t b;
		b.data  = beat_word(id, idx, mac);
		b.bytes = bytes;
		b.last  = last;
		b.abort = abort;
		return b;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp)
		else fail_run($sformatf("Error %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic wait_ack(input string what);
		int n;
		for (n = 0; n < TIMEOUT && !o_wb_ack; n++) begin
			@(posedge i_clk);
			#1;
		end
		if (!o_wb_ack)
			fail_run({"Timeout: no bus ack for ", what});
	endtask

	task automatic reg_write(input cpunet_pkg::reg_addr_e addr, input logic [31:0] data);
		i_wb_stb  = 1'b1;
		i_wb_we   = 1'b1;
		i_wb_addr = addr;
		i_wb_data = data;
		@(posedge i_clk);
		#1;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		wait_ack("register write");
	endtask

	task automatic reg_read(input cpunet_pkg::reg_addr_e addr, output logic [31:0] data);
		i_wb_stb  = 1'b1;
		i_wb_we   = 1'b0;
		i_wb_addr = addr;
		@(posedge i_clk);
		#1;
		i_wb_stb = 1'b0;
		wait_ack("register read");
		data = o_wb_data;
	endtask

	// Reads again until the value settles or time runs out
	task automatic poll_reg(input string name, input cpunet_pkg::reg_addr_e addr,
		input logic [31:0] exp);
		logic [31:0] val;
		int          n;
		reg_read(addr, val);
		for (n = 0; n < TIMEOUT && val !== exp; n++)
			reg_read(addr, val);
		check_value(name, 64'(exp), 64'(val));
	endtask

	task automatic wait_int(input logic level, input string name);
		int n;
		for (n = 0; n < TIMEOUT && o_rx_int !== level; n++) begin
			@(posedge i_clk);
			#1;
		end
		if (o_rx_int !== level)
			fail_run({"Timeout: o_rx_int did not change in test ", name});
	endtask

	task automatic wait_dma_idle(input string name);
		int n;
		for (n = 0; n < TIMEOUT && o_dma.cyc; n++) begin
			@(posedge i_clk);
			#1;
		end
		if (o_dma.cyc)
			fail_run({"Timeout: DMA cycle never ended in test ", name});
	endtask

	// Ready comes from registers only and holds until the edge
	task automatic send_beat(input netpkt_pkg::pkt_beat_t beat);
		int   n;
		logic rdy;
		i_rx_valid = 1'b1;
		i_rx       = beat;
		rdy        = 1'b0;
		for (n = 0; n < TIMEOUT && !rdy; n++) begin
			rdy = o_rx_ready;
			@(posedge i_clk);
			#1;
		end
		i_rx_valid = 1'b0;
		if (!rdy)
			fail_run("Timeout: packet beat never accepted");
	endtask

	task automatic send_packet(input int id, input logic [47:0] mac, input int nbeats,
		input int last_bytes, input int abort_at);
		int   i;
		logic last;
		for (i = 0; i < nbeats; i++) begin
			last = (i == nbeats - 1);
			send_beat(make_beat(id, i, mac, last, last ? 3'(last_bytes) : 3'd0, i == abort_at));
			if (i == abort_at)
				break;
		end
	endtask

	// Length word at the slot and data words after it with wrap
	task automatic check_packet(input string name, input int base, input int size,
		input int slot, input int id, input logic [47:0] mac, input int nbeats,
		input int last_bytes);
		int i;
		int total;
		total = (nbeats - 1) * 8 + ((last_bytes == 0) ? 8 : last_bytes);
		check_value({name, " length word"}, 64'(total), mem[base + slot]);
		for (i = 0; i < nbeats; i++)
			check_value($sformatf("%s data word %0d", name, i), beat_word(id, i, mac),
				mem[base + (slot + 1 + i) % size]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// DMA memory model
	////////////////////////////////////////////////////////////////////////////

	// Random stall and an answer on the cycle after acceptance
	always begin
		@(posedge i_clk);
		#1;
		i_dma_ack   = ack_due;
		i_dma_err   = err_due;
		ack_due     = 1'b0;
		err_due     = 1'b0;
		lfsr        = lfsr_next(lfsr);
		i_dma_stall = lfsr[0];
		if (o_dma.stb === 1'b1 && !i_dma_stall) begin
			if (err_arm) begin
				err_due = 1'b1;
				err_arm = 1'b0;
			end else begin
				mem[o_dma.addr[11:0]] = o_dma.data;
				write_count++;
				ack_due = 1'b1;
			end
		end
	end

	// Bound protocol checker
	always @(posedge i_clk) begin
		if (dut_i.u_props.fails != 0)
			fail_run("Protocol assertion failed in the bound checker");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		i_clk       = 1'b0;
		i_reset     = 1'b1;
		i_wb_stb    = 1'b0;
		i_wb_we     = 1'b0;
		i_wb_addr   = cpunet_pkg::CONTROL;
		i_wb_data   = '0;
		i_rx_valid  = 1'b0;
		i_rx        = '0;
		i_dma_stall = 1'b0;
		i_dma_ack   = 1'b0;
		i_dma_err   = 1'b0;
		lfsr        = 32'h629a;
		ack_due     = 1'b0;
		err_due     = 1'b0;
		err_arm     = 1'b0;
		write_count = 0;
		repeat (8) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		// Reset values and register readback
		check_value("registers o_rx_int", 0, o_rx_int);
		check_value("registers dma cyc", 0, o_dma.cyc);
		check_value("registers o_rx_ready", 0, o_rx_ready);
		poll_reg("registers MAC_HI", cpunet_pkg::MAC_HI, 32'(CPU_MAC[47:32]));
		poll_reg("registers MAC_LO", cpunet_pkg::MAC_LO, CPU_MAC[31:0]);
		reg_write(cpunet_pkg::BUF_BASE, 32'h100);
		reg_write(cpunet_pkg::BUF_SIZE, 32'd16);
		poll_reg("registers BUF_BASE", cpunet_pkg::BUF_BASE, 32'h100);
		poll_reg("registers BUF_SIZE", cpunet_pkg::BUF_SIZE, 32'd16);

		// Matching packet of 3 beats into an empty buffer
		reg_write(cpunet_pkg::CONTROL, 32'h2);
		send_packet(1, CPU_MAC, 3, 5, -1);
		wait_int(1'b1, "matching");
		check_packet("matching", 'h100, 16, 0, 1, CPU_MAC, 3, 5);
		poll_reg("matching WR_PTR", cpunet_pkg::WR_PTR, 32'd4);
		poll_reg("matching RX_PKTS", cpunet_pkg::RX_PKTS, 32'd1);
		check_value("matching o_rx_int", 1, o_rx_int);
		reg_write(cpunet_pkg::RD_PTR, 32'd4);
		wait_int(1'b0, "matching");

		// Wrong MAC swallowed and then taken in promiscuous mode
		wc = write_count;
		send_packet(2, BAD_MAC, 3, 2, -1);
		poll_reg("filtering RX_DROPS", cpunet_pkg::RX_DROPS, 32'd1);
		check_value("filtering DMA writes", 64'(wc), 64'(write_count));
		reg_write(cpunet_pkg::CONTROL, 32'h3);
		send_packet(2, BAD_MAC, 3, 2, -1);
		wait_int(1'b1, "filtering");
		check_packet("filtering", 'h100, 16, 4, 2, BAD_MAC, 3, 2);
		poll_reg("filtering WR_PTR", cpunet_pkg::WR_PTR, 32'd8);
		reg_write(cpunet_pkg::RD_PTR, 32'd8);
		reg_write(cpunet_pkg::CONTROL, 32'h2);

		// Abort on the second beat and the next packet in the same slot
		send_packet(4, CPU_MAC, 3, 0, 1);
		poll_reg("abort RX_DROPS", cpunet_pkg::RX_DROPS, 32'd2);
		poll_reg("abort WR_PTR", cpunet_pkg::WR_PTR, 32'd8);
		send_packet(5, CPU_MAC, 2, 0, -1);
		wait_int(1'b1, "abort");
		check_packet("abort", 'h100, 16, 8, 5, CPU_MAC, 2, 0);
		poll_reg("abort WR_PTR after", cpunet_pkg::WR_PTR, 32'd11);
		reg_write(cpunet_pkg::RD_PTR, 32'd11);

		// Second packet blocks on the unread first one in a six word ring
		reg_write(cpunet_pkg::BUF_BASE, 32'h200);
		reg_write(cpunet_pkg::BUF_SIZE, 32'd6);
		send_packet(6, CPU_MAC, 2, 3, -1);
		wait_int(1'b1, "backpressure");
		check_packet("backpressure first", 'h200, 6, 0, 6, CPU_MAC, 2, 3);
		send_beat(make_beat(7, 0, CPU_MAC, 1'b0, 3'd0, 1'b0));
		wait_dma_idle("backpressure");
		check_value("backpressure o_rx_ready", 0, o_rx_ready);
		reg_write(cpunet_pkg::RD_PTR, 32'd3);
		send_beat(make_beat(7, 1, CPU_MAC, 1'b0, 3'd0, 1'b0));
		send_beat(make_beat(7, 2, CPU_MAC, 1'b0, 3'd0, 1'b0));
		send_beat(make_beat(7, 3, CPU_MAC, 1'b1, 3'd0, 1'b0));
		poll_reg("backpressure WR_PTR", cpunet_pkg::WR_PTR, 32'd2);
		check_packet("backpressure second", 'h200, 6, 3, 7, CPU_MAC, 4, 0);
		reg_write(cpunet_pkg::RD_PTR, 32'd2);

		// Error on the first write and the tail skipped after the clear
		wc      = write_count;
		err_arm = 1'b1;
		send_beat(make_beat(8, 0, CPU_MAC, 1'b0, 3'd0, 1'b0));
		poll_reg("bus error CONTROL", cpunet_pkg::CONTROL, 32'h6);
		check_value("bus error o_rx_ready", 0, o_rx_ready);
		reg_write(cpunet_pkg::CONTROL, 32'h6);
		send_beat(make_beat(8, 1, CPU_MAC, 1'b1, 3'd0, 1'b0));
		poll_reg("bus error RX_DROPS", cpunet_pkg::RX_DROPS, 32'd3);
		check_value("bus error DMA writes", 64'(wc), 64'(write_count));
		send_packet(9, CPU_MAC, 2, 7, -1);
		wait_int(1'b1, "bus error");
		check_packet("bus error", 'h200, 6, 0, 9, CPU_MAC, 2, 7);
		poll_reg("bus error WR_PTR", cpunet_pkg::WR_PTR, 32'd3);
		poll_reg("bus error RX_PKTS", cpunet_pkg::RX_PKTS, 32'd6);

		if (dut_i.u_props.fails != 0)
			fail_run($sformatf("Protocol assertions failed %0d times", dut_i.u_props.fails));
		else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* list.f */
logic/netpkt_pkg.sv
logic/cpunet_pkg.sv
logic/mac_filter.sv
logic/rx_vfifo_writer.sv
logic/cpunet_regs.sv
logic/cpunet_rx.sv
tb/cpunet_properties.sv
tb/cpunet_tb.sv
